/* hdl/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;

    // base opcodes of the RV32I integer set.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // shared by op_imm and op_reg, every value is legal.
    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_ops_t;

    typedef struct packed {
        alu_ops_t alu_op;
        logic     alu_src_imm;
        logic     alu_src_pc;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     jump;
    } rv32i_ctrl_t;

    // what the decode stage hands to execute.
    typedef struct packed {
        word_t       pc;
        rv32i_opcode opcode;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        word_t       rs1_data;
        word_t       rs2_data;
        word_t       imm;
        rv32i_ctrl_t ctrl;
        logic        trap;
    } rv32i_decoded_t;

endpackage

`default_nettype wire

/* hdl/decode_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// combinational link between the decoder and the control ROM.
interface ctrl_rom_if
    import rv32i_pkg::*;
();
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    rv32i_ctrl_t ctrl;

    modport requester (output opcode, output funct3, output funct7, input ctrl);
    modport responder (input opcode, input funct3, input funct7, output ctrl);
endinterface

// two read ports, data comes back in the same cycle.
interface regfile_rd_if
    import rv32i_pkg::*;
();
    logic [4:0] rs1;
    logic [4:0] rs2;
    word_t      rs1_data;
    word_t      rs2_data;

    modport requester (output rs1, output rs2, input rs1_data, input rs2_data);
    modport responder (input rs1, input rs2, output rs1_data, output rs2_data);
endinterface

`default_nettype wire

/* hdl/control_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module control_rom
    import rv32i_pkg::*;
(
    ctrl_rom_if.responder rom
);

    // funct7 bit 5 picks sub and sra, sub only exists for register ops.
    function automatic alu_ops_t arith_op(input logic [2:0] f3, input logic alt,
                                          input logic allow_sub);
        arith_funct3_t op;
        op = arith_funct3_t'(f3);
        case (op)
            add:     arith_op = (alt && allow_sub) ? alu_sub : alu_add;
            sll:     arith_op = alu_sll;
            slt:     arith_op = alu_slt;
            sltu:    arith_op = alu_sltu;
            axor:    arith_op = alu_xor;
            sr:      arith_op = alt ? alu_sra : alu_srl;
            aor:     arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    endfunction

    always_comb begin
        rom.ctrl = '0;
        case (rom.opcode)
            op_lui: begin
                rom.ctrl.alu_op      = alu_pass_b;
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
            end
            op_auipc: begin
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.alu_src_pc  = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
            end
            op_jal: begin
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.alu_src_pc  = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
                rom.ctrl.jump        = 1'b1;
            end
            op_jalr: begin
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
                rom.ctrl.jump        = 1'b1;
            end
            op_br: begin
                // alu forms the target, the compare happens in execute.
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.alu_src_pc  = 1'b1;
                rom.ctrl.branch      = 1'b1;
            end
            op_load: begin
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
                rom.ctrl.mem_read    = 1'b1;
            end
            op_store: begin
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.mem_write   = 1'b1;
            end
            op_imm: begin
                rom.ctrl.alu_op      = arith_op(rom.funct3, rom.funct7[5], 1'b0);
                rom.ctrl.alu_src_imm = 1'b1;
                rom.ctrl.reg_write   = 1'b1;
            end
            op_reg: begin
                rom.ctrl.alu_op    = arith_op(rom.funct3, rom.funct7[5], 1'b1);
                rom.ctrl.reg_write = 1'b1;
            end
            default: rom.ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int XLEN      = 32,
    parameter int REG_COUNT = 32
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    regfile_rd_if.responder      rd,
    input  wire logic            we,
    input  wire logic [4:0]      waddr,
    input  wire logic [XLEN-1:0] wdata
);

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [XLEN-1:0] regs [REG_COUNT];

    // x0 and indices past the implemented set read as zero.
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0 || int'(idx) >= REG_COUNT) begin
            read_reg = '0;
        end else begin
            read_reg = regs[idx[IDX_W-1:0]];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0 && int'(waddr) < REG_COUNT) begin
            regs[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // no bypass, a write in this cycle is seen one cycle later.
    assign rd.rs1_data = read_reg(rd.rs1);
    assign rd.rs2_data = read_reg(rd.rs2);

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import rv32i_pkg::*;
(
    input  wire word_t        instr,
    input  wire word_t        pc,
    output rv32i_decoded_t    dec,
    ctrl_rom_if.requester     rom,
    regfile_rd_if.requester   rf
);

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    word_t       i_imm;
    word_t       s_imm;
    word_t       b_imm;
    word_t       u_imm;
    word_t       j_imm;
    logic        trap;

    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];

    // all immediates take their sign from bit 31.
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rom.opcode = opcode;
    assign rom.funct3 = funct3;
    assign rom.funct7 = instr[31:25];

    assign rf.rs1 = instr[19:15];
    assign rf.rs2 = instr[24:20];

    always_comb begin : trap_check
        trap = 1'b0;
        case (opcode)
            op_lui, op_auipc, op_imm, op_reg, op_jal, op_jalr: ;
            op_br: begin
                case (branch_funct3_t'(funct3))
                    beq, bne, blt, bge, bltu, bgeu: ;
                    default: trap = 1'b1;
                endcase
            end
            op_load: begin
                case (load_funct3_t'(funct3))
                    lb, lh, lw, lbu, lhu: ;
                    default: trap = 1'b1;
                endcase
            end
            op_store: begin
                case (store_funct3_t'(funct3))
                    sb, sh, sw: ;
                    default: trap = 1'b1;
                endcase
            end
            default: trap = 1'b1;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.pc       = pc;
        dec.opcode   = opcode;
        dec.funct3   = funct3;
        dec.rd       = instr[11:7];
        dec.rs1_data = rf.rs1_data;
        dec.rs2_data = rf.rs2_data;
        dec.ctrl     = rom.ctrl;
        dec.trap     = trap;
        case (opcode)
            op_lui, op_auipc: dec.imm = u_imm;
            op_jal:           dec.imm = j_imm;
            op_br:            dec.imm = b_imm;
            op_store:         dec.imm = s_imm;
            op_reg:           dec.imm = '0;
            default:          dec.imm = i_imm;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import rv32i_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           stall,
    input  wire logic           flush,
    input  wire logic           in_valid,
    input  wire rv32i_decoded_t in_dec,
    output logic                out_valid,
    output rv32i_decoded_t      out_dec
);

    // the packet carries fixed 32-bit words.
    if (XLEN != $bits(word_t)) begin : g_xlen_check
        $error("id_ex_reg: XLEN differs from the packet word width");
    end

    logic           valid_q;
    rv32i_decoded_t dec_q;

    // flush beats stall, payload fields keep their old value.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q    <= 1'b0;
            dec_q.ctrl <= '0;
            dec_q.trap <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
            dec_q   <= in_dec;
        end
    end

    assign out_valid = valid_q;
    assign out_dec   = dec_q;

endmodule

`default_nettype wire

/* hdl/rv32i_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode
    import rv32i_pkg::*;
#(
    parameter int XLEN      = 32,
    parameter int REG_COUNT = 32
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            if_valid,
    input  wire logic [31:0]     if_instr,
    input  wire logic [XLEN-1:0] if_pc,
    input  wire logic            stall,
    input  wire logic            flush,
    input  wire logic            wb_we,
    input  wire logic [4:0]      wb_rd,
    input  wire logic [XLEN-1:0] wb_data,
    output logic                 ex_valid,
    output logic [XLEN-1:0]      ex_pc,
    output logic [6:0]           ex_opcode,
    output logic [2:0]           ex_funct3,
    output logic [4:0]           ex_rd,
    output logic [XLEN-1:0]      ex_rs1_data,
    output logic [XLEN-1:0]      ex_rs2_data,
    output logic [XLEN-1:0]      ex_imm,
    output logic [3:0]           ex_alu_op,
    output logic                 ex_alu_src_imm,
    output logic                 ex_alu_src_pc,
    output logic                 ex_reg_write,
    output logic                 ex_mem_read,
    output logic                 ex_mem_write,
    output logic                 ex_branch,
    output logic                 ex_jump,
    output logic                 ex_trap
);

    ctrl_rom_if   rom_if ();
    regfile_rd_if rf_rd_if ();

    rv32i_decoded_t id_dec;
    rv32i_decoded_t ex_dec;

    control_rom u_control_rom (.rom(rom_if.responder));

    regfile #(.XLEN(XLEN), .REG_COUNT(REG_COUNT)) u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (rf_rd_if.responder),
        .we    (wb_we),
        .waddr (wb_rd),
        .wdata (wb_data)
    );

    id_stage u_id_stage (
        .instr (if_instr),
        .pc    (if_pc),
        .dec   (id_dec),
        .rom   (rom_if.requester),
        .rf    (rf_rd_if.requester)
    );

    id_ex_reg #(.XLEN(XLEN)) u_id_ex_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (if_valid),
        .in_dec    (id_dec),
        .out_valid (ex_valid),
        .out_dec   (ex_dec)
    );

    // unpack the registered packet onto plain ports.
    assign ex_pc          = ex_dec.pc;
    assign ex_opcode      = ex_dec.opcode;
    assign ex_funct3      = ex_dec.funct3;
    assign ex_rd          = ex_dec.rd;
    assign ex_rs1_data    = ex_dec.rs1_data;
    assign ex_rs2_data    = ex_dec.rs2_data;
    assign ex_imm         = ex_dec.imm;
    assign ex_alu_op      = ex_dec.ctrl.alu_op;
    assign ex_alu_src_imm = ex_dec.ctrl.alu_src_imm;
    assign ex_alu_src_pc  = ex_dec.ctrl.alu_src_pc;
    assign ex_reg_write   = ex_dec.ctrl.reg_write;
    assign ex_mem_read    = ex_dec.ctrl.mem_read;
    assign ex_mem_write   = ex_dec.ctrl.mem_write;
    assign ex_branch      = ex_dec.ctrl.branch;
    assign ex_jump        = ex_dec.ctrl.jump;
    assign ex_trap        = ex_dec.trap;

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // free running, first rising edge at half a period.
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* dv/rv32i_decode_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_checker (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        if_valid,
    input wire logic        stall,
    input wire logic        flush,
    input wire logic        ex_valid,
    input wire logic [31:0] ex_pc,
    input wire logic [31:0] ex_imm,
    input wire logic [3:0]  ex_alu_op,
    input wire logic        ex_alu_src_imm,
    input wire logic        ex_alu_src_pc,
    input wire logic        ex_reg_write,
    input wire logic        ex_mem_read,
    input wire logic        ex_mem_write,
    input wire logic        ex_branch,
    input wire logic        ex_jump,
    input wire logic        ex_trap
);

    logic [10:0] ctrl_bits;

    assign ctrl_bits = {ex_alu_op, ex_alu_src_imm, ex_alu_src_pc, ex_reg_write,
                        ex_mem_read, ex_mem_write, ex_branch, ex_jump};

    // reset leaves a bubble with no control bits set.
    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> !ex_valid && !ex_trap && ctrl_bits == '0)
        else $error("ID/EX register not cleared by reset");

    // flush wins over stall.
    a_flush_drops: assert property (@(posedge clk)
        flush |=> !ex_valid && !ex_trap && ctrl_bits == '0)
        else $error("ID/EX register not cleared by flush");

    a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        !stall && !flush |=> ex_valid == $past(if_valid))
        else $error("ex_valid does not follow if_valid after one cycle");

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(ex_valid) && $stable(ex_pc) && $stable(ex_imm)
            && $stable(ctrl_bits))
        else $error("ID/EX outputs changed while stalled");

endmodule

`default_nettype wire

/* dv/rv32i_decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_tb
    import rv32i_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 8;
    localparam logic [6:0] LEGAL_OPS [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                                             op_load, op_store, op_imm, op_reg};

    logic        clk;
    logic        rst_n;
    logic        if_valid;
    logic [31:0] if_instr;
    logic [31:0] if_pc;
    logic        stall;
    logic        flush;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [6:0]  ex_opcode;
    logic [2:0]  ex_funct3;
    logic [4:0]  ex_rd;
    logic [31:0] ex_rs1_data;
    logic [31:0] ex_rs2_data;
    logic [31:0] ex_imm;
    logic [3:0]  ex_alu_op;
    logic        ex_alu_src_imm;
    logic        ex_alu_src_pc;
    logic        ex_reg_write;
    logic        ex_mem_read;
    logic        ex_mem_write;
    logic        ex_branch;
    logic        ex_jump;
    logic        ex_trap;

    // reference state.
    logic [31:0] shadow [32];
    logic [15:0] lfsr_state;
    logic        exp_valid;
    logic        exp_trap;
    logic [31:0] exp_pc;
    logic [31:0] exp_fields;
    logic [31:0] exp_rs1;
    logic [31:0] exp_rs2;
    logic [31:0] exp_imm;
    logic [31:0] exp_ctrl;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    logic        timed_out;

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk(clk));

    rv32i_decode #(.XLEN(32), .REG_COUNT(32)) uut (.*);

    bind rv32i_decode rv32i_decode_checker u_checker (.*);

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        case (w[6:0])
            op_lui, op_auipc: model_imm = {w[31:12], 12'd0};
            op_jal:   model_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            op_br:    model_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            op_store: model_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            op_reg:   model_imm = 32'd0;
            default:  model_imm = {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    // sub only exists for register ops while sra exists for both.
    function automatic logic [3:0] model_alu(input logic [2:0] f3, input logic alt,
                                             input logic reg_op);
        case (f3)
            3'd0:    model_alu = (alt && reg_op) ? alu_sub : alu_add;
            3'd1:    model_alu = alu_sll;
            3'd2:    model_alu = alu_slt;
            3'd3:    model_alu = alu_sltu;
            3'd4:    model_alu = alu_xor;
            3'd5:    model_alu = alt ? alu_sra : alu_srl;
            3'd6:    model_alu = alu_or;
            default: model_alu = alu_and;
        endcase
    endfunction

    // flags are src_imm, src_pc, reg_write, mem_read, mem_write, branch, jump.
    function automatic logic [10:0] model_ctrl(input logic [31:0] w);
        logic [3:0] alu;
        logic [6:0] flags;
        alu = alu_add;
        case (w[6:0])
            op_lui: begin
                alu = alu_pass_b;
                flags = 7'b1010000;
            end
            op_auipc: flags = 7'b1110000;
            op_jal:   flags = 7'b1110001;
            op_jalr:  flags = 7'b1010001;
            op_br:    flags = 7'b1100010;
            op_load:  flags = 7'b1011000;
            op_store: flags = 7'b1000100;
            op_imm: begin
                alu = model_alu(w[14:12], w[30], 1'b0);
                flags = 7'b1010000;
            end
            op_reg: begin
                alu = model_alu(w[14:12], w[30], 1'b1);
                flags = 7'b0010000;
            end
            default: flags = 7'd0;
        endcase
        model_ctrl = {alu, flags};
    endfunction

    function automatic logic model_trap(input logic [31:0] w);
        case (w[6:0])
            op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg: model_trap = 1'b0;
            op_br:    model_trap = (w[14:12] == 3'd2 || w[14:12] == 3'd3);
            op_load:  model_trap = (w[14:12] == 3'd3 || w[14:12] >= 3'd6);
            op_store: model_trap = (w[14:12] >= 3'd3);
            default:  model_trap = 1'b1;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_outputs(input bit full);
        check_val("ex_valid", {31'd0, ex_valid}, {31'd0, exp_valid});
        check_val("control word", {21'd0, ex_alu_op, ex_alu_src_imm, ex_alu_src_pc,
                  ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jump}, exp_ctrl);
        check_val("ex_trap", {31'd0, ex_trap}, {31'd0, exp_trap});
        if (full) begin
            check_val("ex_pc", ex_pc, exp_pc);
            check_val("opcode/funct3/rd", {17'd0, ex_opcode, ex_funct3, ex_rd}, exp_fields);
            check_val("ex_rs1_data", ex_rs1_data, exp_rs1);
            check_val("ex_rs2_data", ex_rs2_data, exp_rs2);
            check_val("ex_imm", ex_imm, exp_imm);
        end
    endtask

    task automatic step_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_for_valid(output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = ex_valid;
        end
        if (!seen) begin
            $display("Timeout at %0t: ex_valid did not rise within %0d cycles",
                     $time, TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // expected values use the register contents before a write in the same cycle.
    task automatic issue(input logic [31:0] w, input logic [31:0] pc, input logic we,
                         input logic [4:0] wrd, input logic [31:0] wdata);
        int cycles;
        exp_valid  = 1'b1;
        exp_pc     = pc;
        exp_fields = {17'd0, w[6:0], w[14:12], w[11:7]};
        exp_rs1    = shadow[w[19:15]];
        exp_rs2    = shadow[w[24:20]];
        exp_imm    = model_imm(w);
        exp_ctrl   = {21'd0, model_ctrl(w)};
        exp_trap   = model_trap(w);
        if_valid = 1'b1;
        if_instr = w;
        if_pc    = pc;
        wb_we    = we;
        wb_rd    = wrd;
        wb_data  = wdata;
        if (we && wrd != 5'd0) begin
            shadow[wrd] = wdata;
        end
        wait_for_valid(cycles);
        wb_we = 1'b0;
        check_val("latency", cycles, 32'd1);
        compare_outputs(1'b1);
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        if_valid = 1'b0;
        wb_we    = 1'b1;
        wb_rd    = a;
        wb_data  = d;
        step_cycles(1);
        wb_we = 1'b0;
        if (a != 5'd0) begin
            shadow[a] = d;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        step_cycles(10);
        rst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        $display("%-12s %s (%0d checks, %0d errors)", name,
                 (errors == test_errors) ? "pass" : "FAIL",
                 checks - test_checks, errors - test_errors);
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [31:0] p;
        start_test();
        for (int k = 0; k < 9; k++) begin
            for (int n = 0; n < 8; n++) begin
                random_bits(25, r);
                random_bits(30, p);
                issue({r[24:0], LEGAL_OPS[k]}, {p[29:0], 2'b00}, 1'b0, 5'd0, 32'd0);
            end
        end
        finish_test("immediates");
    endtask

    task automatic test_registers();
        logic [31:0] r;
        logic [31:0] d;
        start_test();
        for (int n = 0; n < 24; n++) begin
            random_bits(5, r);
            random_bits(32, d);
            write_reg(r[4:0], d);
        end
        write_reg(5'd0, 32'hffff_ffff);
        issue({7'd0, 5'd0, 5'd0, 3'd0, 5'd1, op_reg}, 32'h0000_0100, 1'b0, 5'd0, 32'd0);
        for (int n = 0; n < 24; n++) begin
            random_bits(15, r);
            issue({7'd0, r[14:5], 3'd0, r[4:0], op_reg}, 32'h0000_0104, 1'b0, 5'd0, 32'd0);
        end
        // write x5 while reading it and read it once more in the next issue.
        d = ~shadow[5];
        issue({7'd0, 5'd6, 5'd5, 3'd0, 5'd1, op_reg}, 32'h0000_0200, 1'b1, 5'd5, d);
        issue({7'd0, 5'd6, 5'd5, 3'd0, 5'd1, op_reg}, 32'h0000_0204, 1'b0, 5'd0, 32'd0);
        finish_test("registers");
    endtask

    task automatic test_control();
        logic [31:0] r;
        start_test();
        for (int k = 0; k < 9; k++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    random_bits(15, r);
                    issue({alt[0] ? 7'h20 : 7'h00, r[14:5], f3[2:0], r[4:0], LEGAL_OPS[k]},
                          32'h0000_0300, 1'b0, 5'd0, 32'd0);
                end
            end
        end
        finish_test("control");
    endtask

    task automatic test_trap();
        logic [31:0] r;
        start_test();
        // branch, load and store are the classes with illegal funct3 values.
        for (int k = 4; k < 7; k++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                random_bits(22, r);
                issue({r[21:5], f3[2:0], r[4:0], LEGAL_OPS[k]}, 32'h0000_0400,
                      1'b0, 5'd0, 32'd0);
            end
        end
        for (int n = 0; n < 40; n++) begin
            random_bits(32, r);
            issue(r, 32'h0000_0404, 1'b0, 5'd0, 32'd0);
        end
        finish_test("trap");
    endtask

    task automatic test_stall_flush();
        logic [31:0] r;
        start_test();
        random_bits(22, r);
        issue({r[21:5], 3'd5, r[4:0], op_store}, 32'h0000_1000, 1'b0, 5'd0, 32'd0);
        random_bits(25, r);
        stall    = 1'b1;
        if_instr = {r[24:0], op_load};
        if_pc    = 32'h0000_2000;
        for (int i = 0; i < 3; i++) begin
            step_cycles(1);
            compare_outputs(1'b1);
        end
        flush = 1'b1;
        step_cycles(1);
        exp_valid = 1'b0;
        exp_ctrl  = 32'd0;
        exp_trap  = 1'b0;
        compare_outputs(1'b0);
        flush = 1'b0;
        stall = 1'b0;
        issue({r[24:0], op_load}, 32'h0000_2000, 1'b0, 5'd0, 32'd0);
        finish_test("stall/flush");
    endtask

    task automatic test_reset();
        logic [31:0] r;
        start_test();
        if_valid = 1'b1;
        if_instr = {12'h001, 5'd3, 3'd2, 5'd4, op_load};
        apply_reset();
        if_valid  = 1'b0;
        exp_valid = 1'b0;
        exp_ctrl  = 32'd0;
        exp_trap  = 1'b0;
        compare_outputs(1'b0);
        for (int n = 0; n < 8; n++) begin
            random_bits(15, r);
            issue({7'd0, r[14:5], 3'd0, r[4:0], op_reg}, 32'h0000_0500, 1'b0, 5'd0, 32'd0);
        end
        finish_test("reset");
    endtask

    initial begin
        rst_n      = 1'b0;
        if_valid   = 1'b0;
        if_instr   = 32'd0;
        if_pc      = 32'd0;
        stall      = 1'b0;
        flush      = 1'b0;
        wb_we      = 1'b0;
        wb_rd      = 5'd0;
        wb_data    = 32'd0;
        lfsr_state = 16'd56884;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        apply_reset();
        if (!timed_out) test_immediates();
        if (!timed_out) test_registers();
        if (!timed_out) test_control();
        if (!timed_out) test_trap();
        if (!timed_out) test_stall_flush();
        if (!timed_out) test_reset();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv32i_decode.f */
hdl/rv32i_pkg.sv
hdl/decode_ifs.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/id_stage.sv
hdl/id_ex_reg.sv
hdl/rv32i_decode.sv
dv/tb_clock.sv
dv/rv32i_decode_checker.sv
dv/rv32i_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.
# A run that stops on an error also counts as a failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rv32i_decode_tb \
    -f rv32i_decode.f -o rv32i_decode_sim > build.log 2>&1 ||
    { cat build.log; echo "build failed, see build.log"; exit 1; }
./obj_dir/rv32i_decode_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
grep -q "%Error" sim.log && echo "Test failed" >> sim.log
cat sim.log && ! grep -q "Test failed" sim.log
